// File: axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int id_w    = 4;
  localparam int addr_w  = plb_pkg::addr_w;     // AXI side uses the bus address width
  localparam int len_w   = 8;
  localparam int size_w  = 3;
  localparam int burst_w = 2;
  localparam int resp_w  = 2;

  localparam logic [burst_w-1:0] burst_incr = 2'b01;

  localparam logic [resp_w-1:0] resp_okay   = 2'b00;
  localparam logic [resp_w-1:0] resp_slverr = 2'b10;

  // AW request
  typedef struct packed {
    logic [id_w-1:0]    id;
    logic [addr_w-1:0]  addr;
    logic [len_w-1:0]   len;                    // Beats minus one
    logic [size_w-1:0]  size;                   // Log2 of bytes per beat
    logic [burst_w-1:0] burst;
  } ax_req_t;

  // W beat, sized to the PLB data path
  typedef struct packed {
    logic [plb_pkg::data_w-1:0] data;
    logic [plb_pkg::be_w-1:0]   strb;
    logic                       last;
  } w_beat_t;

  // B response
  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [resp_w-1:0] resp;
  } b_rsp_t;

endpackage

`default_nettype wire

// File: build.f
plb_pkg.sv
axi_pkg.sv
ipsaxi_fifo.sv
ipsaxi_wr_burst.sv
ipsaxi_wr.sv
ipsaxi_wr_assertions.sv
tb_ipsaxi_wr.sv

// File: ipsaxi_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module ipsaxi_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = plb_pkg::fifo_depth,
  parameter int  NF_MARGIN = plb_pkg::nf_margin
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire payload_t in_data,
  input  wire           in_valid,
  output logic          in_ready,
  output logic          nf,
  output payload_t      out_data,
  output logic          out_valid,
  input  wire           out_ready
);

  localparam int pw = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cw = $clog2(DEPTH + 1);

  localparam logic [pw-1:0] last_ptr = pw'(DEPTH - 1);
  localparam logic [cw-1:0] full_cnt = cw'(DEPTH);
  localparam logic [cw-1:0] nf_level = cw'(DEPTH - NF_MARGIN);

  payload_t      mem [DEPTH];
  logic [pw-1:0] wr_ptr;
  logic [pw-1:0] rd_ptr;
  logic [cw-1:0] count;
  logic          do_push;
  logic          do_pop;

  assign in_ready  = (count != full_cnt);
  assign out_valid = (count != '0);
  assign nf        = (count >= nf_level);       // Free slots at or below margin
  assign out_data  = mem[rd_ptr];

  assign do_push = in_valid && in_ready;
  assign do_pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + pw'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + pw'(1);
      end
      count <= count + cw'(do_push) - cw'(do_pop);
    end
  end

endmodule

`default_nettype wire

// File: ipsaxi_wr.sv
`timescale 1ns/1ns
`default_nettype none

module ipsaxi_wr (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire axi_pkg::ax_req_t aw,
  input  wire                   awvalid,
  output logic                  awready,
  input  wire axi_pkg::w_beat_t w,
  input  wire                   wvalid,
  output logic                  wready,
  output axi_pkg::b_rsp_t       b,
  output logic                  bvalid,
  input  wire                   bready,
  output plb_pkg::plb_wr_t      rd,
  output logic                  rdvld,
  input  wire                   rdrdy
);

  axi_pkg::ax_req_t aw_head;
  logic             aw_head_vld;
  logic             aw_pop;

  axi_pkg::w_beat_t w_head;
  logic             w_head_vld;
  logic             w_pop;

  plb_pkg::plb_wr_t plb_req;
  logic             plb_push;
  logic             plb_nf;

  axi_pkg::b_rsp_t  b_rsp;
  logic             b_push;
  logic             b_nf;

  ipsaxi_fifo #(
    .payload_t (axi_pkg::ax_req_t),
    .DEPTH     (plb_pkg::fifo_depth),
    .NF_MARGIN (plb_pkg::nf_margin)
  ) u_aw_fifo (
    .clk (clk), .rst_n (rst_n),
    .in_data (aw), .in_valid (awvalid), .in_ready (awready), .nf (),
    .out_data (aw_head), .out_valid (aw_head_vld), .out_ready (aw_pop)
  );

  ipsaxi_fifo #(
    .payload_t (axi_pkg::w_beat_t),
    .DEPTH     (plb_pkg::fifo_depth),
    .NF_MARGIN (plb_pkg::nf_margin)
  ) u_w_fifo (
    .clk (clk), .rst_n (rst_n),
    .in_data (w), .in_valid (wvalid), .in_ready (wready), .nf (),
    .out_data (w_head), .out_valid (w_head_vld), .out_ready (w_pop)
  );

  ipsaxi_wr_burst u_burst (
    .clk (clk), .rst_n (rst_n),
    .aw (aw_head), .aw_valid (aw_head_vld), .aw_pop (aw_pop),
    .w (w_head), .w_valid (w_head_vld), .w_pop (w_pop),
    .plb_nf (plb_nf), .b_nf (b_nf),
    .plb_push (plb_push), .plb (plb_req),
    .b_push (b_push), .b (b_rsp)
  );

  // Nearly-full margin leaves room for in-flight beats
  ipsaxi_fifo #(
    .payload_t (plb_pkg::plb_wr_t),
    .DEPTH     (plb_pkg::fifo_depth),
    .NF_MARGIN (plb_pkg::nf_margin)
  ) u_plb_fifo (
    .clk (clk), .rst_n (rst_n),
    .in_data (plb_req), .in_valid (plb_push), .in_ready (), .nf (plb_nf),
    .out_data (rd), .out_valid (rdvld), .out_ready (rdrdy)
  );

  ipsaxi_fifo #(
    .payload_t (axi_pkg::b_rsp_t),
    .DEPTH     (plb_pkg::fifo_depth),
    .NF_MARGIN (plb_pkg::nf_margin)
  ) u_b_fifo (
    .clk (clk), .rst_n (rst_n),
    .in_data (b_rsp), .in_valid (b_push), .in_ready (), .nf (b_nf),
    .out_data (b), .out_valid (bvalid), .out_ready (bready)
  );

endmodule

`default_nettype wire

// File: ipsaxi_wr_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module ipsaxi_wr_assertions (
  input wire                   clk,
  input wire                   rst_n,
  input wire                   awready,
  input wire                   wready,
  input wire plb_pkg::plb_wr_t rd,
  input wire                   rdvld,
  input wire                   rdrdy,
  input wire axi_pkg::b_rsp_t  b,
  input wire                   bvalid,
  input wire                   bready
);

  int reset_fails = 0;
  int rd_fails = 0;
  int b_fails = 0;

  // Every FIFO comes out of reset empty
  reset_state: assert property (@(posedge clk)
    !rst_n |=> (!rdvld && !bvalid && awready && wready))
    else begin
      reset_fails++;
      $error("Output handshakes not in reset state");
    end

  rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rdvld && !rdrdy) |=> (rdvld && $stable(rd)))
    else begin
      rd_fails++;
      $error("PLB request dropped or changed while waiting");
    end

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid && !bready) |=> (bvalid && $stable(b)))
    else begin
      b_fails++;
      $error("B response dropped or changed while waiting");
    end

endmodule

bind ipsaxi_wr ipsaxi_wr_assertions u_chk (
  .clk (clk), .rst_n (rst_n),
  .awready (awready), .wready (wready),
  .rd (rd), .rdvld (rdvld), .rdrdy (rdrdy),
  .b (b), .bvalid (bvalid), .bready (bready)
);

`default_nettype wire

// File: ipsaxi_wr_burst.sv
`timescale 1ns/1ns
`default_nettype none

module ipsaxi_wr_burst (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire axi_pkg::ax_req_t aw,
  input  wire                   aw_valid,
  output logic                  aw_pop,
  input  wire axi_pkg::w_beat_t w,
  input  wire                   w_valid,
  output logic                  w_pop,
  input  wire                   plb_nf,
  input  wire                   b_nf,
  output logic                  plb_push,
  output plb_pkg::plb_wr_t      plb,
  output logic                  b_push,
  output axi_pkg::b_rsp_t       b
);

  typedef logic [axi_pkg::addr_w-1:0] addr_t;
  typedef logic [axi_pkg::len_w-1:0]  len_t;

  // Open burst
  axi_pkg::ax_req_t req;
  logic             busy;
  len_t             cnt;                        // Index of the next beat
  addr_t            next_addr;

  // Beat being popped this cycle
  axi_pkg::ax_req_t cur;
  logic             stall;
  logic             start;
  logic             take;
  len_t             beat_idx;
  addr_t            beat_addr;
  addr_t            beat_step;
  logic             beat_final;

  // Stage 1
  logic                          s1_vld;
  plb_pkg::plb_wr_t              s1_plb;
  logic                          s1_final;
  logic                          s1_last;
  logic [axi_pkg::id_w-1:0]      s1_id;
  logic [axi_pkg::burst_w-1:0]   s1_burst;

  assign stall = plb_nf || b_nf;
  assign start = !busy && aw_valid && w_valid && !stall;
  assign take  = start || (busy && w_valid && !stall);

  assign aw_pop = start;
  assign w_pop  = take;

  // First beat comes straight from the AW head
  assign cur        = start ? aw : req;
  assign beat_idx   = start ? '0 : cnt;
  assign beat_addr  = start ? aw.addr : next_addr;
  assign beat_step  = addr_t'(1) << cur.size;
  assign beat_final = (beat_idx == cur.len);  // wlast plays no part here

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (take) begin
      busy <= !beat_final;                      // Idle again right after final beat
      cnt  <= beat_idx + len_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req <= aw;
    end
    if (take) begin
      next_addr <= beat_addr + beat_step;       // Plain rollover, any burst type
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= take;
    end
  end

  always_ff @(posedge clk) begin
    s1_plb.addr <= beat_addr;
    s1_plb.data <= w.data;
    s1_plb.be   <= w.strb;
    s1_final    <= beat_final;
    s1_last     <= w.last;
    s1_id       <= cur.id;
    s1_burst    <= cur.burst;
  end

  // Stage 2 drives the outputs
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      plb_push <= 1'b0;
      b_push   <= 1'b0;
    end else begin
      plb_push <= s1_vld;
      b_push   <= s1_vld && s1_final;           // Same cycle as the final PLB push
    end
  end

  always_ff @(posedge clk) begin
    plb  <= s1_plb;
    b.id <= s1_id;
    if ((s1_burst != axi_pkg::burst_incr) || !s1_last) begin
      b.resp <= axi_pkg::resp_slverr;
    end else begin
      b.resp <= axi_pkg::resp_okay;
    end
  end

endmodule

`default_nettype wire

// File: plb_pkg.sv
`default_nettype none

package plb_pkg;

  localparam int addr_w = 32;                   // Bus address width
  localparam int data_w = 32;                   // Bus data width
  localparam int be_w   = data_w / 8;           // One enable per byte

  localparam int fifo_depth = 8;

  // Free slots at which nearly-full rises, covering the engine's two
  // in-flight stages plus the beat popped in the same cycle
  localparam int nf_margin  = 3;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [be_w-1:0]   be;
  } plb_wr_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_ipsaxi_wr -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_ipsaxi_wr)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

// File: tb_ipsaxi_wr.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ipsaxi_wr;

  localparam int n_bursts   = 80;
  localparam int max_beats  = n_bursts * 8;
  localparam int wait_limit = 2000;             // Cycles per handshake wait
  localparam int end_limit  = 40000;

  logic             clk = 1'b0;
  logic             rst_n;
  axi_pkg::ax_req_t aw;
  logic             awvalid;
  logic             awready;
  axi_pkg::w_beat_t w;
  logic             wvalid;
  logic             wready;
  axi_pkg::b_rsp_t  b;
  logic             bvalid;
  logic             bready;
  plb_pkg::plb_wr_t rd;
  logic             rdvld;
  logic             rdrdy;

  // Stimulus and expected results, filled once before reset ends
  axi_pkg::ax_req_t aw_list [n_bursts];
  axi_pkg::w_beat_t w_list [max_beats];
  plb_pkg::plb_wr_t exp_plb [max_beats];
  axi_pkg::b_rsp_t  exp_b [n_bursts];
  int               n_beats = 0;

  int   plb_idx = 0;
  int   b_idx = 0;
  int   err_val = 0;
  int   err_order = 0;
  int   err_reset = 0;
  logic aw_to;
  logic w_to;

  always #20 clk = ~clk;

  ipsaxi_wr u_dut (
    .clk (clk), .rst_n (rst_n),
    .aw (aw), .awvalid (awvalid), .awready (awready),
    .w (w), .wvalid (wvalid), .wready (wready),
    .b (b), .bvalid (bvalid), .bready (bready),
    .rd (rd), .rdvld (rdvld), .rdrdy (rdrdy)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expv,
                             input logic [31:0] actv);
    assert (actv == expv) else begin
      err_val++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expv, actv);
    end
  endtask

  task automatic check_reset_bit(input string name, input logic expv, input logic actv);
    assert (actv === expv) else begin
      err_reset++;
      $display("ERR %0t %s expected %b actual %b", $time, name, expv, actv);
    end
  endtask

  task automatic build_bursts();
    logic [31:0] r;
    logic [31:0] a;
    logic        drop_last;
    int          i;
    int          j;
    r = 32'h6f8f;
    for (i = 0; i < n_bursts; i++) begin
      r = lcg_next(r);
      aw_list[i].id    = r[31:28];
      aw_list[i].len   = {5'd0, r[27:25]};
      aw_list[i].size  = 3'(r[23:16] % 8'd3);
      aw_list[i].burst = (r[15:13] == 3'd0) ? (r[12] ? 2'b10 : 2'b00) : axi_pkg::burst_incr;
      drop_last        = (r[11:9] == 3'd0);      // Final beat without wlast
      r = lcg_next(r);
      a = (i % 8 == 7) ? {28'hfffffff, r[31:28]} : r;  // Near the top to force rollover
      aw_list[i].addr = a;
      exp_b[i].id = aw_list[i].id;
      if (aw_list[i].burst == axi_pkg::burst_incr && !drop_last) begin
        exp_b[i].resp = axi_pkg::resp_okay;
      end else begin
        exp_b[i].resp = axi_pkg::resp_slverr;
      end
      for (j = 0; j <= int'(aw_list[i].len); j++) begin
        r = lcg_next(r);
        w_list[n_beats].data = r;
        r = lcg_next(r);
        w_list[n_beats].strb = r[31:28];
        w_list[n_beats].last = (j == int'(aw_list[i].len)) && !drop_last;
        exp_plb[n_beats].addr = a;
        exp_plb[n_beats].data = w_list[n_beats].data;
        exp_plb[n_beats].be   = w_list[n_beats].strb;
        a = a + (32'd1 << aw_list[i].size);
        n_beats++;
      end
    end
  endtask

  initial begin : aw_drive
    int i;
    int t;
    aw_to = 1'b0;
    awvalid <= 1'b0;
    aw <= '0;
    t = 0;
    while (rst_n !== 1'b1 && t < wait_limit) begin
      @(posedge clk);
      t++;
    end
    if (rst_n !== 1'b1) begin
      aw_to = 1'b1;
      $display("Timed out waiting for reset release in the AW driver");
    end
    for (i = 0; i < n_bursts && !aw_to; i++) begin
      awvalid <= 1'b1;
      aw <= aw_list[i];
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!awready && t < wait_limit);
      if (!awready) begin
        aw_to = 1'b1;
        $display("Timed out waiting for awready on burst %0d", i);
      end
    end
    awvalid <= 1'b0;
  end

  initial begin : w_drive
    int          k;
    int          t;
    logic [31:0] r;
    w_to = 1'b0;
    wvalid <= 1'b0;
    w <= '0;
    r = 32'h6f8f ^ 32'h5a5a_0001;
    t = 0;
    while (rst_n !== 1'b1 && t < wait_limit) begin
      @(posedge clk);
      t++;
    end
    if (rst_n !== 1'b1) begin
      w_to = 1'b1;
      $display("Timed out waiting for reset release in the W driver");
    end
    for (k = 0; k < n_beats && !w_to; k++) begin
      r = lcg_next(r);
      if (r[31:30] == 2'b00) begin
        wvalid <= 1'b0;                         // Gap of 1 to 4 cycles
        repeat (int'(r[29:28]) + 1) @(posedge clk);
      end
      wvalid <= 1'b1;
      w <= w_list[k];
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!wready && t < wait_limit);
      if (!wready) begin
        w_to = 1'b1;
        $display("Timed out waiting for wready on beat %0d", k);
      end
    end
    wvalid <= 1'b0;
  end

  initial begin : ready_drive
    logic [31:0] rr;
    logic [31:0] br;
    int          cyc;
    rdrdy <= 1'b0;
    bready <= 1'b0;
    rr = 32'h6f8f ^ 32'h0f0f_1234;
    br = 32'h6f8f ^ 32'h3c3c_8765;
    cyc = 0;
    forever begin
      @(posedge clk);
      rr = lcg_next(rr);
      br = lcg_next(br);
      // Long mostly-stalled windows push the output FIFOs to nearly full
      if (cyc % 256 >= 192) begin
        rdrdy <= (rr[31:29] == 3'd0);
      end else begin
        rdrdy <= (rr[31:30] != 2'b00);
      end
      if (cyc % 128 >= 32 && cyc % 128 < 64) begin
        bready <= (br[31:29] == 3'd0);
      end else begin
        bready <= (br[31:30] != 2'b00);
      end
      cyc++;
    end
  end

  always @(posedge clk) begin : monitor
    plb_pkg::plb_wr_t ep;
    axi_pkg::b_rsp_t  eb;
    if (rst_n === 1'b1 && rdvld && rdrdy) begin
      assert (plb_idx < n_beats) else begin
        err_order++;
        $display("PLB request at %0t arrived with none outstanding", $time);
      end
      if (plb_idx < n_beats) begin
        ep = exp_plb[plb_idx];
        check_value("rd.addr", ep.addr, rd.addr);
        check_value("rd.data", ep.data, rd.data);
        check_value("rd.be", 32'(ep.be), 32'(rd.be));
        plb_idx++;
      end
    end
    if (rst_n === 1'b1 && bvalid && bready) begin
      assert (b_idx < n_bursts) else begin
        err_order++;
        $display("B response at %0t arrived with none outstanding", $time);
      end
      if (b_idx < n_bursts) begin
        eb = exp_b[b_idx];
        check_value("b.id", 32'(eb.id), 32'(b.id));
        check_value("b.resp", 32'(eb.resp), 32'(b.resp));
        b_idx++;
      end
    end
  end

  initial begin : main
    int t;
    int timeouts;
    int asrt_fails;
    int total;
    build_bursts();
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_bit("rdvld", 1'b0, rdvld);
    check_reset_bit("bvalid", 1'b0, bvalid);
    check_reset_bit("awready", 1'b1, awready);
    check_reset_bit("wready", 1'b1, wready);
    timeouts = 0;
    t = 0;
    while (!(plb_idx == n_beats && b_idx == n_bursts) && !aw_to && !w_to &&
           t < end_limit) begin
      @(posedge clk);
      t++;
    end
    if (!(plb_idx == n_beats && b_idx == n_bursts) && !aw_to && !w_to) begin
      timeouts++;
      $display("Timed out with %0d of %0d PLB requests and %0d of %0d responses seen",
               plb_idx, n_beats, b_idx, n_bursts);
    end
    repeat (20) @(posedge clk);                 // Room for any extra outputs
    timeouts = timeouts + int'(aw_to) + int'(w_to);
    asrt_fails = u_dut.u_chk.reset_fails + u_dut.u_chk.rd_fails + u_dut.u_chk.b_fails;
    total = err_val + err_order + err_reset + timeouts + asrt_fails;
    $display("Error counts value %0d order %0d reset %0d timeout %0d assertion %0d",
             err_val, err_order, err_reset, timeouts, asrt_fails);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
